// File: hw/p_hit_settings.svh
`ifndef P_HIT_SETTINGS_SVH
`define P_HIT_SETTINGS_SVH

// fixed-point format
`define DATA_WIDTH 32
`define Q_BITS 16

// buffering
`define FIFO_DEPTH 16
`define DOT_OUT_DEPTH 4

`endif

// File: hw/p_hit_pkg.sv
`default_nettype none

`include "p_hit_settings.svh"

package p_hit_pkg;

    typedef logic signed [`DATA_WIDTH-1:0] fixed_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

// File: hw/fifo_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module fifo_array #(
    parameter int ARRAY_SIZE = 3,
    parameter int DEPTH = `FIFO_DEPTH
) (
    input logic clock,
    input logic rst_n,
    input logic wr_en,
    input p_hit_pkg::fixed_t din [ARRAY_SIZE-1:0],
    output logic full,
    input logic rd_en,
    output p_hit_pkg::fixed_t dout [ARRAY_SIZE-1:0],
    output logic empty
);
    import p_hit_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    fixed_t mem [DEPTH-1:0][ARRAY_SIZE-1:0];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic do_wr;
    logic do_rd;

    assign full = (count == (PTR_W + 1)'(DEPTH));
    assign empty = (count == '0);

    // writes while full and reads while empty are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head of queue shown without a read latency
    always_comb begin
        dout = mem[rd_ptr];
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/dot.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module dot #(
    parameter int Q_BITS = `Q_BITS
) (
    input logic clock,
    input logic rst_n,
    input p_hit_pkg::fixed_t x [2:0],
    input p_hit_pkg::fixed_t y [2:0],
    input logic in_empty,
    output logic in_rd_en,
    output p_hit_pkg::fixed_t out,
    output logic out_empty,
    input logic out_rd_en
);
    import p_hit_pkg::*;

    localparam int CREDIT_W = $clog2(`DOT_OUT_DEPTH + 1);

    fixed_t prod_q [2:0];
    fixed_t sum_q [0:0];
    fixed_t res_dout [0:0];
    logic prod_vld;
    logic sum_vld;
    logic out_pop;
    logic [CREDIT_W-1:0] credits;

    // full 64-bit product, floor shift, keep low word
    function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
        logic signed [2*`DATA_WIDTH-1:0] wide;
        wide = a * b;
        return fixed_t'(wide >>> Q_BITS);
    endfunction

    // credits cover results in flight plus results stored
    assign in_rd_en = !in_empty && (credits < CREDIT_W'(`DOT_OUT_DEPTH));
    assign out_pop = out_rd_en && !out_empty;
    assign out = res_dout[0];

    always_ff @(posedge clock) begin
        for (int i = 0; i < 3; i++) begin
            prod_q[i] <= fixed_mul(x[i], y[i]);
        end
        sum_q[0] <= prod_q[0] + prod_q[1] + prod_q[2];
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            prod_vld <= 1'b0;
            sum_vld <= 1'b0;
            credits <= '0;
        end else begin
            prod_vld <= in_rd_en;
            sum_vld <= prod_vld;
            credits <= credits + CREDIT_W'(in_rd_en) - CREDIT_W'(out_pop);
        end
    end

    // never fills, credits hold reads back first
    fifo_array #(
        .ARRAY_SIZE (1),
        .DEPTH      (`DOT_OUT_DEPTH)
    ) u_result_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .wr_en      (sum_vld),
        .din        (sum_q),
        .full       (),
        .rd_en      (out_rd_en),
        .dout       (res_dout),
        .empty      (out_empty)
    );

endmodule

`default_nettype wire

// File: hw/p_hit_numerator.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module p_hit_numerator #(
    parameter int Q_BITS = `Q_BITS
) (
    input logic clock,
    input logic rst_n,
    input p_hit_pkg::fixed_t normal [2:0],
    input p_hit_pkg::fixed_t v0 [2:0],
    input p_hit_pkg::fixed_t origin [2:0],
    input logic in_wr_en,
    output logic in_full,
    output p_hit_pkg::fixed_t out,
    output logic out_empty,
    input logic out_rd_en
);
    import p_hit_pkg::*;

    fixed_t normal_q [2:0];
    fixed_t v0_q [2:0];
    fixed_t origin_q [2:0];
    fixed_t dot_v0;
    fixed_t dot_origin;
    logic [2:0] full_flags;
    logic [2:0] empty_flags;
    logic [1:0] dot_empty;
    logic fifo_rd_en;
    logic fifo_empty;

    assign in_full = |full_flags;
    assign fifo_empty = |empty_flags;
    assign out_empty = |dot_empty;
    assign out = dot_v0 - dot_origin;

    fifo_array #(.ARRAY_SIZE(3), .DEPTH(`FIFO_DEPTH)) u_normal_fifo (
        .clock (clock), .rst_n (rst_n),
        .wr_en (in_wr_en), .din (normal), .full (full_flags[0]),
        .rd_en (fifo_rd_en), .dout (normal_q), .empty (empty_flags[0])
    );

    fifo_array #(.ARRAY_SIZE(3), .DEPTH(`FIFO_DEPTH)) u_v0_fifo (
        .clock (clock), .rst_n (rst_n),
        .wr_en (in_wr_en), .din (v0), .full (full_flags[1]),
        .rd_en (fifo_rd_en), .dout (v0_q), .empty (empty_flags[1])
    );

    fifo_array #(.ARRAY_SIZE(3), .DEPTH(`FIFO_DEPTH)) u_origin_fifo (
        .clock (clock), .rst_n (rst_n),
        .wr_en (in_wr_en), .din (origin), .full (full_flags[2]),
        .rd_en (fifo_rd_en), .dout (origin_q), .empty (empty_flags[2])
    );

    dot #(.Q_BITS(Q_BITS)) u_dot_v0 (
        .clock (clock), .rst_n (rst_n),
        .x (normal_q), .y (v0_q), .in_empty (fifo_empty), .in_rd_en (fifo_rd_en),
        .out (dot_v0), .out_empty (dot_empty[0]), .out_rd_en (out_rd_en)
    );

    // same inputs and credits as u_dot_v0, so its read strobe matches
    dot #(.Q_BITS(Q_BITS)) u_dot_origin (
        .clock (clock), .rst_n (rst_n),
        .x (normal_q), .y (origin_q), .in_empty (fifo_empty), .in_rd_en (),
        .out (dot_origin), .out_empty (dot_empty[1]), .out_rd_en (out_rd_en)
    );

endmodule

`default_nettype wire

// File: hw/p_hit_denominator.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module p_hit_denominator #(
    parameter int Q_BITS = `Q_BITS
) (
    input logic clock,
    input logic rst_n,
    input p_hit_pkg::fixed_t normal [2:0],
    input p_hit_pkg::fixed_t dir [2:0],
    input logic in_wr_en,
    output logic in_full,
    output p_hit_pkg::fixed_t out,
    output logic out_empty,
    input logic out_rd_en
);
    import p_hit_pkg::*;

    fixed_t normal_q [2:0];
    fixed_t dir_q [2:0];
    logic [1:0] full_flags;
    logic [1:0] empty_flags;
    logic fifo_rd_en;
    logic fifo_empty;

    assign in_full = |full_flags;
    assign fifo_empty = |empty_flags;

    fifo_array #(.ARRAY_SIZE(3), .DEPTH(`FIFO_DEPTH)) u_normal_fifo (
        .clock (clock), .rst_n (rst_n),
        .wr_en (in_wr_en), .din (normal), .full (full_flags[0]),
        .rd_en (fifo_rd_en), .dout (normal_q), .empty (empty_flags[0])
    );

    fifo_array #(.ARRAY_SIZE(3), .DEPTH(`FIFO_DEPTH)) u_dir_fifo (
        .clock (clock), .rst_n (rst_n),
        .wr_en (in_wr_en), .din (dir), .full (full_flags[1]),
        .rd_en (fifo_rd_en), .dout (dir_q), .empty (empty_flags[1])
    );

    dot #(.Q_BITS(Q_BITS)) u_dot (
        .clock (clock), .rst_n (rst_n),
        .x (normal_q), .y (dir_q), .in_empty (fifo_empty), .in_rd_en (fifo_rd_en),
        .out (out), .out_empty (out_empty), .out_rd_en (out_rd_en)
    );

endmodule

`default_nettype wire

// File: hw/fixed_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module fixed_divider #(
    parameter int Q_BITS = `Q_BITS
) (
    input logic clock,
    input logic rst_n,
    input p_hit_pkg::fixed_t dividend,
    input p_hit_pkg::fixed_t divisor,
    input logic in_empty,
    output logic in_rd_en,
    output p_hit_pkg::fixed_t out,
    output logic out_empty,
    input logic out_rd_en
);
    import p_hit_pkg::*;

    localparam int W = `DATA_WIDTH;
    localparam int STEPS = W + Q_BITS;
    localparam int CNT_W = $clog2(STEPS);
    localparam fixed_t DIV_ZERO_VAL = fixed_t'({1'b0, {(W - 1){1'b1}}});

    div_state_t state;
    logic [CNT_W-1:0] step;
    logic [STEPS-1:0] quo;
    logic [W-1:0] rem;
    logic [W-1:0] dvs;
    logic neg;
    fixed_t result;

    logic [W-1:0] dividend_mag;
    logic [W-1:0] divisor_mag;
    logic [W:0] rem_shift;
    logic [W:0] rem_sub;
    logic fits;
    logic [W-1:0] rem_next;
    logic [STEPS-1:0] quo_next;
    logic last_step;
    logic div_zero;

    assign in_rd_en = (state == DIV_IDLE) && !in_empty;
    assign out_empty = (state != DIV_DONE);
    assign out = result;
    assign div_zero = (divisor == '0);
    assign last_step = (state == DIV_BUSY) && (step == CNT_W'(STEPS - 1));

    always_comb begin
        dividend_mag = dividend[W-1] ? -dividend : dividend;
        divisor_mag = divisor[W-1] ? -divisor : divisor;
        // one restoring step, next dividend bit into the remainder
        rem_shift = {rem, quo[STEPS-1]};
        rem_sub = rem_shift - {1'b0, dvs};
        fits = (rem_shift >= {1'b0, dvs});
        rem_next = fits ? rem_sub[W-1:0] : rem_shift[W-1:0];
        quo_next = {quo[STEPS-2:0], fits};
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            step <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (in_rd_en) begin
                        step <= '0;
                        state <= div_zero ? DIV_DONE : DIV_BUSY;
                    end
                end
                DIV_BUSY: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (out_rd_en) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            // dividend magnitude pre-scaled by the fraction bits
            quo <= {dividend_mag, {Q_BITS{1'b0}}};
            rem <= '0;
            dvs <= divisor_mag;
            neg <= dividend[W-1] ^ divisor[W-1];
            if (div_zero) begin
                result <= DIV_ZERO_VAL;
            end
        end else if (state == DIV_BUSY) begin
            quo <= quo_next;
            rem <= rem_next;
            if (last_step) begin
                result <= neg ? -fixed_t'(quo_next[W-1:0]) : fixed_t'(quo_next[W-1:0]);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/p_hit_distance.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module p_hit_distance #(
    parameter int Q_BITS = `Q_BITS
) (
    input logic clock,
    input logic rst_n,
    input p_hit_pkg::fixed_t num_normal [2:0],
    input p_hit_pkg::fixed_t v0 [2:0],
    input p_hit_pkg::fixed_t origin [2:0],
    input p_hit_pkg::fixed_t den_normal [2:0],
    input p_hit_pkg::fixed_t dir [2:0],
    input logic in_wr_en [1:0],
    output logic in_full [1:0],
    output p_hit_pkg::fixed_t out,
    output logic out_empty,
    input logic out_rd_en
);
    import p_hit_pkg::*;

    fixed_t num_out;
    fixed_t den_out;
    logic num_empty;
    logic den_empty;
    logic div_rd_en;
    logic div_in_empty;

    // divider waits for both scalars of a ray
    assign div_in_empty = num_empty || den_empty;

    p_hit_numerator #(.Q_BITS(Q_BITS)) u_numerator (
        .clock (clock), .rst_n (rst_n),
        .normal (num_normal), .v0 (v0), .origin (origin),
        .in_wr_en (in_wr_en[0]), .in_full (in_full[0]),
        .out (num_out), .out_empty (num_empty), .out_rd_en (div_rd_en)
    );

    p_hit_denominator #(.Q_BITS(Q_BITS)) u_denominator (
        .clock (clock), .rst_n (rst_n),
        .normal (den_normal), .dir (dir),
        .in_wr_en (in_wr_en[1]), .in_full (in_full[1]),
        .out (den_out), .out_empty (den_empty), .out_rd_en (div_rd_en)
    );

    fixed_divider #(.Q_BITS(Q_BITS)) u_divider (
        .clock (clock), .rst_n (rst_n),
        .dividend (num_out), .divisor (den_out),
        .in_empty (div_in_empty), .in_rd_en (div_rd_en),
        .out (out), .out_empty (out_empty), .out_rd_en (out_rd_en)
    );

endmodule

`default_nettype wire

// File: tb/p_hit_distance_assert.sv
`timescale 1ns/1ps
`default_nettype none

module p_hit_distance_assert (
    input logic clock,
    input logic rst_n,
    input p_hit_pkg::fixed_t out,
    input logic out_empty,
    input logic out_rd_en
);

    // result port comes out of reset empty
    reset_empty: assert property (@(posedge clock) !rst_n |=> out_empty)
        else $error("out_empty is not high in the cycle after reset");

    no_read_when_empty: assert property (@(posedge clock) disable iff (!rst_n)
        !(out_rd_en && out_empty))
        else $error("out_rd_en asserted while out_empty is high");

    // held result must not move until it is taken
    hold_result: assert property (@(posedge clock) disable iff (!rst_n)
        (!out_empty && !out_rd_en) |=> $stable(out))
        else $error("out changed while a result was waiting");

endmodule

bind p_hit_distance p_hit_distance_assert u_assert (
    .clock     (clock),
    .rst_n     (rst_n),
    .out       (out),
    .out_empty (out_empty),
    .out_rd_en (out_rd_en)
);

`default_nettype wire

// File: tb/p_hit_distance_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "p_hit_settings.svh"

module p_hit_distance_tb;
    import p_hit_pkg::*;

    localparam int NUM_ROWS = 16;
    localparam int WAIT_LIMIT = 400;
    localparam fixed_t ONE = 32'sh0001_0000;
    // input FIFO plus dot results plus the ray held in the divider
    localparam int RAY_CAPACITY = `FIFO_DEPTH + `DOT_OUT_DEPTH + 1;

    logic clock;
    logic rst_n;
    fixed_t num_normal [2:0];
    fixed_t v0 [2:0];
    fixed_t origin [2:0];
    fixed_t den_normal [2:0];
    fixed_t dir [2:0];
    logic in_wr_en [1:0];
    logic in_full [1:0];
    fixed_t out;
    logic out_empty;
    logic out_rd_en;

    // one ray per row
    fixed_t tab_nn [NUM_ROWS][3];
    fixed_t tab_v0 [NUM_ROWS][3];
    fixed_t tab_org [NUM_ROWS][3];
    fixed_t tab_dn [NUM_ROWS][3];
    fixed_t tab_dir [NUM_ROWS][3];
    fixed_t tab_exp [NUM_ROWS];
    integer seed;
    int accepted [2];
    int errors;

    p_hit_distance u_p_hit_distance (
        .clock (clock), .rst_n (rst_n),
        .num_normal (num_normal), .v0 (v0), .origin (origin),
        .den_normal (den_normal), .dir (dir),
        .in_wr_en (in_wr_en), .in_full (in_full),
        .out (out), .out_empty (out_empty), .out_rd_en (out_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic fixed_t mul_q(input fixed_t a, input fixed_t b);
        longint wide;
        wide = longint'(a) * longint'(b);
        return fixed_t'(wide >>> `Q_BITS);
    endfunction

    // expected t for one table row
    function automatic fixed_t hit_distance(input int r);
        fixed_t dot_v0;
        fixed_t dot_org;
        fixed_t num;
        fixed_t den;
        logic [63:0] num_mag;
        logic [63:0] den_mag;
        logic [63:0] quo;
        dot_v0 = '0;
        dot_org = '0;
        den = '0;
        for (int k = 0; k < 3; k++) begin
            dot_v0 = dot_v0 + mul_q(tab_nn[r][k], tab_v0[r][k]);
            dot_org = dot_org + mul_q(tab_nn[r][k], tab_org[r][k]);
            den = den + mul_q(tab_dn[r][k], tab_dir[r][k]);
        end
        num = dot_v0 - dot_org;
        if (den == '0) begin
            return 32'sh7fff_ffff;
        end
        num_mag = {32'd0, num[31] ? -num : num};
        den_mag = {32'd0, den[31] ? -den : den};
        quo = (num_mag << `Q_BITS) / den_mag;
        return (num[31] ^ den[31]) ? -fixed_t'(quo[31:0]) : fixed_t'(quo[31:0]);
    endfunction

    task automatic build_table;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < 3; k++) begin
                tab_nn[r][k] = fixed_t'($random(seed)) >>> 13;
                tab_v0[r][k] = fixed_t'($random(seed)) >>> 13;
                tab_org[r][k] = fixed_t'($random(seed)) >>> 13;
                tab_dn[r][k] = fixed_t'($random(seed)) >>> 13;
                tab_dir[r][k] = fixed_t'($random(seed)) >>> 13;
            end
        end
        // axis-aligned rays with t = 5 before the edits below
        for (int r = 0; r < 5; r++) begin
            tab_nn[r] = '{0, 0, ONE};
            tab_v0[r] = '{0, 0, 10 * ONE};
            tab_org[r] = '{0, 0, 0};
            tab_dn[r] = '{0, 0, ONE};
            tab_dir[r] = '{0, 0, 2 * ONE};
        end
        tab_org[1][2] = 20 * ONE;
        tab_dir[2][2] = -3 * ONE;
        tab_org[3][2] = 17 * ONE;
        tab_dir[3][2] = -3 * ONE;
        // normal perpendicular to dir
        tab_dn[4] = '{ONE, 0, 0};
        tab_dir[4] = '{0, ONE, 0};
        tab_nn[5] = '{32'sh8000, 32'sh18000, -ONE};
        tab_v0[5] = '{32'sh20000, -32'sh4000, 32'sh30000};
        tab_org[5] = '{32'shc000, ONE, 32'sh8000};
        tab_dn[5] = '{ONE, ONE, ONE};
        tab_dir[5] = '{32'sh8000, -32'sh4000, 32'sh2000};
        for (int r = 0; r < NUM_ROWS; r++) begin
            tab_exp[r] = hit_distance(r);
        end
    endtask

    task automatic check_value(input fixed_t got, input fixed_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("Errors found");
        $fatal(1, "wait timeout");
    endtask

    task automatic next_cycle;
        @(posedge clock);
        #1;
    endtask

    task automatic load_group(input int g, input int r);
        for (int k = 0; k < 3; k++) begin
            if (g == 0) begin
                num_normal[k] = tab_nn[r][k];
                v0[k] = tab_v0[r][k];
                origin[k] = tab_org[r][k];
            end else begin
                den_normal[k] = tab_dn[r][k];
                dir[k] = tab_dir[r][k];
            end
        end
        in_wr_en[g] = 1'b1;
    endtask

    task automatic write_ray(input int r);
        int waited;
        waited = 0;
        while (in_full[0] || in_full[1]) begin
            if (waited == WAIT_LIMIT) fail_timeout("in_full to fall before a write");
            next_cycle();
            waited++;
        end
        load_group(0, r);
        load_group(1, r);
        next_cycle();
        in_wr_en[0] = 1'b0;
        in_wr_en[1] = 1'b0;
    endtask

    task automatic read_result(input fixed_t exp, input string what);
        int waited;
        waited = 0;
        while (out_empty) begin
            if (waited == WAIT_LIMIT) fail_timeout("out_empty to fall");
            next_cycle();
            waited++;
        end
        check_value(out, exp, what);
        out_rd_en = 1'b1;
        next_cycle();
        out_rd_en = 1'b0;
    endtask

    // each group keeps writing while its own full flag is low
    task automatic fill_until_full;
        int waited;
        waited = 0;
        accepted[0] = 0;
        accepted[1] = 0;
        while (!(in_full[0] && in_full[1])) begin
            if (waited == WAIT_LIMIT) fail_timeout("both in_full bits to rise");
            for (int g = 0; g < 2; g++) begin
                if (!in_full[g]) begin
                    load_group(g, accepted[g] % NUM_ROWS);
                    accepted[g]++;
                end else begin
                    in_wr_en[g] = 1'b0;
                end
            end
            next_cycle();
            waited++;
        end
        in_wr_en[0] = 1'b0;
        in_wr_en[1] = 1'b0;
    endtask

    initial begin
        seed = 32'h3ad5;
        errors = 0;
        rst_n = 1'b0;
        out_rd_en = 1'b0;
        in_wr_en[0] = 1'b0;
        in_wr_en[1] = 1'b0;
        for (int k = 0; k < 3; k++) begin
            num_normal[k] = '0;
            v0[k] = '0;
            origin[k] = '0;
            den_normal[k] = '0;
            dir[k] = '0;
        end
        build_table();
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;

        check_value(fixed_t'(in_full[0]), 0, "in_full[0] after reset");
        check_value(fixed_t'(in_full[1]), 0, "in_full[1] after reset");
        check_value(fixed_t'(out_empty), 1, "out_empty after reset");

        write_ray(0);
        read_result(tab_exp[0], "single ray");
        check_value(fixed_t'(out_empty), 1, "out_empty after single read");

        // signs, truncation and divide by zero sit in rows 1 to 5
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_ray(r);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            read_result(tab_exp[r], $sformatf("streaming row %0d", r));
        end

        fill_until_full();
        check_value(accepted[0], RAY_CAPACITY, "rays accepted by group 0");
        check_value(accepted[1], RAY_CAPACITY, "rays accepted by group 1");
        for (int i = 0; i < accepted[0]; i++) begin
            read_result(tab_exp[i % NUM_ROWS], $sformatf("back-pressure ray %0d", i));
        end
        check_value(fixed_t'(out_empty), 1, "out_empty after drain");

        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/p_hit_pkg.sv
hw/fifo_array.sv
hw/dot.sv
hw/p_hit_numerator.sv
hw/p_hit_denominator.sv
hw/fixed_divider.sv
hw/p_hit_distance.sv
tb/p_hit_distance_assert.sv
tb/p_hit_distance_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
    --top-module p_hit_distance_tb -f sources.f -o p_hit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/p_hit_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Errors found" "$log"; then
    echo "simulation reported failure"
    exit 1
elif [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
